//--- hdl/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regCount = 32;
	localparam int regIdxWidth = 5;
	localparam int imemAddrWidth = 8;
	// Both memories are word addressed
	localparam int dmemAddrWidth = 8;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regIdxWidth-1:0] regIdxT;
	typedef logic [imemAddrWidth-1:0] pcT;

	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opLi = 6'b001001,
		opLw = 6'b100011,
		opSw = 6'b101011,
		opBne = 6'b000101,
		opXori = 6'b001110
	} opcodeT;

	typedef enum logic [5:0] {
		funcAdd = 6'b100000,
		funcSub = 6'b100010,
		funcSlt = 6'b101010
	} funcT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluSlt,
		aluXor,
		aluPassImm
	} aluOpT;

	typedef struct packed {
		logic valid;
		pcT pc;
		wordT instr;
	} fetchPktT;

	typedef struct packed {
		logic valid;
		aluOpT aluOp;
		logic useImm;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic writes;
		regIdxT rs;
		regIdxT rt;
		regIdxT dest;
		wordT aVal;
		wordT bVal;
		wordT imm;
		pcT pc;
	} decodePktT;

	typedef struct packed {
		logic valid;
		logic isLoad;
		logic isStore;
		logic writes;
		regIdxT dest;
		wordT result;
		wordT storeData;
	} execPktT;

	// MEM/WB payload and retire port
	typedef struct packed {
		logic valid;
		regIdxT dest;
		wordT data;
	} retireT;

	typedef struct packed {
		logic valid;
		pcT target;
	} redirectT;

endpackage

//--- hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input fetchPktT fetched,
	input decodePktT inExec,
	input retireT writeback,
	output decodePktT decoded,
	output logic loadUseStall
);

	wordT regFile [regCount];
	opcodeT opcode;
	funcT func;
	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	logic usesRs;
	logic usesRt;

	assign opcode = opcodeT'(fetched.instr[31:26]);
	assign func = funcT'(fetched.instr[5:0]);
	assign rs = fetched.instr[25:21];
	assign rt = fetched.instr[20:16];
	assign rd = fetched.instr[15:11];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
		end else if (writeback.valid) begin
			regFile[writeback.dest] <= writeback.data;
		end
	end

	// Write-first read, r0 hardwired to zero
	function automatic wordT readReg(regIdxT idx);
		if (idx == '0) begin
			return '0;
		end
		if (writeback.valid && writeback.dest == idx) begin
			return writeback.data;
		end
		return regFile[idx];
	endfunction

	always_comb begin
		decoded = '0;
		decoded.valid = fetched.valid;
		decoded.aluOp = aluAdd;
		decoded.rs = rs;
		decoded.rt = rt;
		decoded.dest = rt;
		decoded.aVal = readReg(rs);
		decoded.bVal = readReg(rt);
		decoded.imm = {{(dataWidth-16){fetched.instr[15]}}, fetched.instr[15:0]};
		decoded.pc = fetched.pc;
		usesRs = 1'b1;
		usesRt = 1'b0;
		case (opcode)
			opRType: begin
				decoded.dest = rd;
				decoded.writes = 1'b1;
				usesRt = 1'b1;
				case (func)
					funcAdd: decoded.aluOp = aluAdd;
					funcSub: decoded.aluOp = aluSub;
					funcSlt: decoded.aluOp = aluSlt;
					default: decoded.valid = 1'b0;
				endcase
			end
			opLi: begin
				decoded.aluOp = aluPassImm;
				decoded.useImm = 1'b1;
				decoded.writes = 1'b1;
				usesRs = 1'b0;
			end
			opXori: begin
				decoded.aluOp = aluXor;
				decoded.useImm = 1'b1;
				decoded.writes = 1'b1;
			end
			opLw: begin
				decoded.useImm = 1'b1;
				decoded.isLoad = 1'b1;
				decoded.writes = 1'b1;
			end
			opSw: begin
				decoded.useImm = 1'b1;
				decoded.isStore = 1'b1;
				usesRt = 1'b1;
			end
			opBne: begin
				decoded.isBranch = 1'b1;
				usesRt = 1'b1;
			end
			default: decoded.valid = 1'b0;
		endcase
		if (decoded.dest == '0) begin
			decoded.writes = 1'b0;
		end
	end

	// Load in execute feeding this instruction
	assign loadUseStall = fetched.valid && inExec.valid && inExec.isLoad && inExec.writes
		&& ((usesRs && inExec.dest == rs) || (usesRt && inExec.dest == rt));

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
	input decodePktT decoded,
	input execPktT inMem,
	input retireT writeback,
	output execPktT executed,
	output redirectT redirect
);

	wordT opA;
	wordT opB;
	wordT aluB;
	wordT aluResult;
	wordT target;

	// Younger result first; loads in EX/MEM are covered by the stall
	function automatic wordT forwardOperand(regIdxT idx, wordT regVal);
		if (inMem.valid && inMem.writes && !inMem.isLoad && inMem.dest == idx) begin
			return inMem.result;
		end
		if (writeback.valid && writeback.dest == idx) begin
			return writeback.data;
		end
		return regVal;
	endfunction

	assign opA = forwardOperand(decoded.rs, decoded.aVal);
	assign opB = forwardOperand(decoded.rt, decoded.bVal);
	assign aluB = decoded.useImm ? decoded.imm : opB;

	always_comb begin
		case (decoded.aluOp)
			aluAdd: aluResult = opA + aluB;
			aluSub: aluResult = opA - aluB;
			aluSlt: aluResult = wordT'($signed(opA) < $signed(aluB));
			aluXor: aluResult = opA ^ aluB;
			aluPassImm: aluResult = aluB;
			default: aluResult = '0;
		endcase
	end

	assign executed.valid = decoded.valid;
	assign executed.isLoad = decoded.isLoad;
	assign executed.isStore = decoded.isStore;
	assign executed.writes = decoded.writes;
	assign executed.dest = decoded.dest;
	assign executed.result = aluResult;
	assign executed.storeData = opB;

	// Branch target relative to the following word
	assign target = wordT'(decoded.pc) + wordT'(1) + decoded.imm;
	assign redirect.valid = decoded.valid && decoded.isBranch && (opA != opB);
	assign redirect.target = target[imemAddrWidth-1:0];

endmodule

//--- hdl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input redirectT redirect,
	input logic imemWe,
	input pcT imemAddr,
	input wordT imemData,
	output fetchPktT fetch
);

	wordT instrMem [2**imemAddrWidth];
	pcT pc;

	// Load port, used while the core sits in reset
	always_ff @(posedge clk) begin
		if (imemWe) begin
			instrMem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (redirect.valid) begin
			pc <= redirect.target;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	// Squashing is done by IF/ID, so every fetched word is live here
	assign fetch.valid = 1'b1;
	assign fetch.pc = pc;
	assign fetch.instr = instrMem[pc];

endmodule

//--- hdl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; (
	input logic clk,
	input execPktT executed,
	output retireT memOut
);

	wordT dataMem [2**dmemAddrWidth];
	logic [dmemAddrWidth-1:0] addr;
	wordT loadData;

	// Upper address bits are ignored
	assign addr = executed.result[dmemAddrWidth-1:0];
	assign loadData = dataMem[addr];

	always_ff @(posedge clk) begin
		if (executed.valid && executed.isStore) begin
			dataMem[addr] <= executed.storeData;
		end
	end

	assign memOut.valid = executed.valid && executed.writes;
	assign memOut.dest = executed.dest;
	assign memOut.data = executed.isLoad ? loadData : executed.result;

endmodule

//--- hdl/pipelineCpu.sv
`timescale 1ns/1ps

module pipelineCpu import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic imemWe,
	input pcT imemAddr,
	input wordT imemData,
	output retireT retire
);

	fetchPktT fetchPkt;
	fetchPktT ifIdQ;
	decodePktT decodedPkt;
	decodePktT idExQ;
	execPktT execPkt;
	execPktT exMemQ;
	retireT memPkt;
	redirectT redirect;
	logic loadUseStall;
	logic ifIdFlush;
	logic idExFlush;

	// Taken branch kills both younger slots, load-use inserts one bubble
	assign ifIdFlush = redirect.valid;
	assign idExFlush = redirect.valid || loadUseStall;

	fetchStage fetchUnit (
		.clk(clk),
		.rst(rst),
		.stall(loadUseStall),
		.redirect(redirect),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.fetch(fetchPkt)
	);

	stageReg #(.payloadT(fetchPktT), .bubble('0)) ifId (
		.clk(clk), .rst(rst), .stall(loadUseStall), .flush(ifIdFlush),
		.d(fetchPkt), .q(ifIdQ)
	);

	decodeStage decodeUnit (
		.clk(clk),
		.rst(rst),
		.fetched(ifIdQ),
		.inExec(idExQ),
		.writeback(retire),
		.decoded(decodedPkt),
		.loadUseStall(loadUseStall)
	);

	stageReg #(.payloadT(decodePktT), .bubble('0)) idEx (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(idExFlush),
		.d(decodedPkt), .q(idExQ)
	);

	executeStage executeUnit (
		.decoded(idExQ),
		.inMem(exMemQ),
		.writeback(retire),
		.executed(execPkt),
		.redirect(redirect)
	);

	stageReg #(.payloadT(execPktT), .bubble('0)) exMem (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
		.d(execPkt), .q(exMemQ)
	);

	memoryStage memoryUnit (
		.clk(clk),
		.executed(exMemQ),
		.memOut(memPkt)
	);

	stageReg #(.payloadT(retireT), .bubble('0)) memWb (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
		.d(memPkt), .q(retire)
	);

endmodule

//--- hdl/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic,
	parameter payloadT bubble = '0
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// Flush wins over stall so a squashed slot never lingers
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			q <= bubble;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Verilator build and run of the pipelined CPU testbench

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal -f verilog.f --top-module pipelineCpuTb -o simv; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "Simulation log holds no pass message"
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi
exit 0

//--- tests/cpuTests.txt
# P <word>: instruction word, stored from address 0 upward
# E <dest> <data>: expected register write, in retire order
P 24010005  # 0  li   r1, 5
P 24020003  # 1  li   r2, 3
P 00221820  # 2  add  r3, r1, r2
P 00612022  # 3  sub  r4, r3, r1
P 0083282A  # 4  slt  r5, r4, r3
P 38A600FF  # 5  xori r6, r5, 0xff
P 0064382A  # 6  slt  r7, r3, r4
P 24080010  # 7  li   r8, 0x10
P AD060002  # 8  sw   r6, 2(r8)
P 8D090002  # 9  lw   r9, 2(r8)
P 01215020  # 10 add  r10, r9, r1
P 14220002  # 11 bne  r1, r2, 14 (taken)
P 240B0BAD  # 12 li   r11, 0xbad (squashed)
P 240C0BAD  # 13 li   r12, 0xbad (squashed)
P 240D0007  # 14 li   r13, 7
P 14820005  # 15 bne  r4, r2 (not taken)
P 240E0009  # 16 li   r14, 9
P 24000055  # 17 li   r0, 0x55
P 000E7820  # 18 add  r15, r0, r14
P 000E8022  # 19 sub  r16, r0, r14
P 0200882A  # 20 slt  r17, r16, r0
P 1420FFFF  # 21 bne  r1, r0, 21 (self loop)
E 01 00000005
E 02 00000003
E 03 00000008
E 04 00000003
E 05 00000001
E 06 000000fe
E 07 00000000
E 08 00000010
E 09 000000fe
E 0a 00000103
E 0d 00000007
E 0e 00000009
E 0f 00000009
E 10 fffffff7
E 11 00000001

//--- tests/pipelineCpuTb.sv
`timescale 1ns/1ps

module pipelineCpuTb import cpuPkg::*; ();

	logic clk;
	logic rst;
	logic imemWe;
	pcT imemAddr;
	wordT imemData;
	retireT retire;

	// Program image and expected retire trace from the data file
	wordT progWords[$];
	regIdxT expDest[$];
	wordT expData[$];

	pipelineCpu i_dut (
		.clk(clk),
		.rst(rst),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.retire(retire)
	);

	always #5 clk = ~clk;

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic compareValue(input string name, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			stopWithFailure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	// P lines carry program words, E lines carry dest and data
	task automatic readTests();
		int fd;
		int count;
		string line;
		wordT word;
		wordT dest;
		fd = $fopen("tests/cpuTests.txt", "r");
		if (fd == 0) begin
			stopWithFailure("Could not open tests/cpuTests.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			count = $fgets(line, fd);
			if (line.substr(0, 0) == "P") begin
				count = $sscanf(line, "P %h", word);
				if (count != 1) begin
					stopWithFailure($sformatf("Malformed program line: %s", line));
				end
				progWords.push_back(word);
			end else if (line.substr(0, 0) == "E") begin
				count = $sscanf(line, "E %h %h", dest, word);
				if (count != 2) begin
					stopWithFailure($sformatf("Malformed expected line: %s", line));
				end
				expDest.push_back(dest[regIdxWidth-1:0]);
				expData.push_back(word);
			end
		end
		$fclose(fd);
		if (progWords.size() == 0 || expData.size() == 0) begin
			stopWithFailure("The test file holds no program words or no expected writes");
		end
		if (progWords.size() > 2**imemAddrWidth) begin
			stopWithFailure("The program does not fit in the instruction memory");
		end
	endtask

	// Core stays in reset while the words go in
	task automatic loadProgram();
		for (int i = 0; i < progWords.size(); i++) begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= pcT'(i);
			imemData <= progWords[i];
		end
		@(posedge clk);
		imemWe <= 1'b0;
		rst <= 1'b0;
	endtask

	task automatic waitRetire(input int index, input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				stopWithFailure($sformatf("Expected write %0d to r%0d never retired",
					index, expDest[index]));
			end
		end while (!retire.valid);
	endtask

	// Self branch at the end keeps the retire port idle
	task automatic checkQuiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (retire.valid) begin
				stopWithFailure($sformatf("Unexpected write to r%0d retired after the program ended",
					retire.dest));
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		readTests();
		repeat (2) @(posedge clk);
		loadProgram();
		for (int i = 0; i < expData.size(); i++) begin
			waitRetire(i, 40);
			compareValue("retire.dest", wordT'(retire.dest), wordT'(expDest[i]));
			compareValue("retire.data", retire.data, expData[i]);
		end
		checkQuiet(50);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- verilog.f
hdl/cpuPkg.sv
hdl/stageReg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipelineCpu.sv
tests/pipelineCpuTb.sv
